// File: sim/write_engine_tb.sv
`timescale 1ns/100ps
`default_nettype none

module write_engine_tb;

	localparam int SEED             = 94471;
	localparam int MAX_ENTRIES      = 64;
	// entries over all tests, and cycles allowed for each
	localparam int TOTAL_ENTRIES    = 84;
	localparam int CYCLES_PER_ENTRY = 20;
	localparam int TEST_COUNT       = 6;
	localparam int TEST_OVERHEAD    = 100;
	localparam int CYCLE_LIMIT      = TOTAL_ENTRIES * CYCLES_PER_ENTRY + TEST_COUNT * TEST_OVERHEAD;

	logic                                    clock;
	logic                                    rstn;
	logic                                    enable;
	logic                                    job_valid;
	logic [write_engine_pkg::ADDR_W-1:0]     job_base_addr;
	logic [write_engine_pkg::SIZE_W-1:0]     job_size;
	logic                                    ms_mode;
	logic                                    cmd_buffer_alfull;
	logic                                    data_0_valid;
	logic [write_engine_pkg::OFFSET_W-1:0]   data_0_offset;
	logic [write_engine_pkg::SIZE_W-1:0]     data_0_size;
	logic [write_engine_pkg::HALF_W-1:0]     data_0_half;
	logic                                    data_1_valid;
	logic [write_engine_pkg::OFFSET_W-1:0]   data_1_offset;
	logic [write_engine_pkg::SIZE_W-1:0]     data_1_size;
	logic [write_engine_pkg::HALF_W-1:0]     data_1_half;
	logic                                    resp_valid;
	logic [write_engine_pkg::SIZE_W-1:0]     resp_size;
	logic                                    cmd_valid;
	logic [write_engine_pkg::ADDR_W-1:0]     cmd_address;
	logic [write_engine_pkg::CMD_SIZE_W-1:0] cmd_size_code;
	logic [write_engine_pkg::OPCODE_W-1:0]   cmd_opcode;
	logic [write_engine_pkg::SIZE_W-1:0]     cmd_real_size;
	logic                                    wr_data_0_valid;
	logic [write_engine_pkg::HALF_W-1:0]     wr_data_0;
	logic                                    wr_data_1_valid;
	logic [write_engine_pkg::HALF_W-1:0]     wr_data_1;
	logic                                    data_buffer_full;
	logic                                    data_buffer_alfull;
	logic [write_engine_pkg::SIZE_W-1:0]     job_counter_done;
	logic                                    job_done;

	// entries of the current job, in push order
	logic [write_engine_pkg::OFFSET_W-1:0] pushed_offset [MAX_ENTRIES];
	logic [write_engine_pkg::SIZE_W-1:0]   pushed_size [MAX_ENTRIES];
	logic [write_engine_pkg::HALF_W-1:0]   pushed_half_0 [MAX_ENTRIES];
	logic [write_engine_pkg::HALF_W-1:0]   pushed_half_1 [MAX_ENTRIES];
	int                                    pushed_count;
	logic [write_engine_pkg::SIZE_W-1:0]   job_total;

	// reference model state
	int                                    issued;
	int                                    answered;
	logic [write_engine_pkg::SIZE_W-1:0]   consumed;
	logic [write_engine_pkg::SIZE_W-1:0]   resp_total;
	logic [write_engine_pkg::SIZE_W-1:0]   resp_total_d1;
	logic [write_engine_pkg::SIZE_W-1:0]   resp_total_d2;
	logic                                  alfull_d1;
	logic                                  alfull_d2;
	int unsigned                           pending_sizes [$];
	logic                                  respond_on;
	logic                                  quiet;

	int    error_count;
	int    tests_run;
	int    tests_failed;
	int    test_mark;
	int    cycle_count;
	string test_name;

	logic [write_engine_pkg::ADDR_W-1:0]     exp_address;
	logic [write_engine_pkg::CMD_SIZE_W-1:0] exp_size_code;
	logic [write_engine_pkg::OPCODE_W-1:0]   exp_opcode;

	write_engine_top dut_i (.*);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	////////////////////
	// helpers
	////////////////////

	function automatic void report_value(string name, logic [511:0] got, logic [511:0] want);
		$display("FAIL %s got %0h expected %0h at %0t", name, got, want, $time);
		error_count++;
	endfunction

	function automatic void report_problem(string text);
		$display("error: %s at %0t", text, $time);
		error_count++;
	endfunction

	// element count in bytes, one line at most
	function automatic logic [write_engine_pkg::CMD_SIZE_W-1:0] expected_size_code(
		logic [write_engine_pkg::SIZE_W-1:0] size);
		if (size * write_engine_pkg::ELEMENT_BYTES > write_engine_pkg::LINE_BYTES)
			return write_engine_pkg::LINE_BYTES;
		return size * write_engine_pkg::ELEMENT_BYTES;
	endfunction

	function automatic logic [write_engine_pkg::HALF_W-1:0] random_half();
		logic [write_engine_pkg::HALF_W-1:0] h;
		h = '0;
		for (int w = 0; w < write_engine_pkg::HALF_W / 32; w++)
			h = {h[write_engine_pkg::HALF_W-33:0], $urandom()};
		return h;
	endfunction

	assign exp_address   = job_base_addr + {32'b0, pushed_offset[issued]};
	assign exp_size_code = expected_size_code(pushed_size[issued]);
	assign exp_opcode    = ms_mode ? write_engine_pkg::WRITE_MS : write_engine_pkg::WRITE_NA;

	////////////////////
	// reference model and responder
	////////////////////

	always @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			pending_sizes.delete();
			resp_valid <= 1'b0;
			resp_size  <= '0;
			resp_total <= '0;
			answered   <= 0;
			issued     <= 0;
			consumed   <= '0;
		end else begin
			// random gaps between responses
			if (respond_on && pending_sizes.size() > 0 && ($urandom() % 4) != 0) begin
				resp_valid <= 1'b1;
				resp_size  <= pending_sizes[0];
				resp_total <= resp_total + pending_sizes[0];
				answered   <= answered + 1;
				void'(pending_sizes.pop_front());
			end else begin
				resp_valid <= 1'b0;
			end
			if (cmd_valid) begin
				pending_sizes.push_back(cmd_real_size);
				issued   <= issued + 1;
				consumed <= consumed + pushed_size[issued];
			end
		end
	end

	// latch plus count stage of the response path
	always @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			resp_total_d1 <= '0;
			resp_total_d2 <= '0;
			alfull_d1     <= 1'b0;
			alfull_d2     <= 1'b0;
		end else begin
			resp_total_d1 <= resp_total;
			resp_total_d2 <= resp_total_d1;
			alfull_d1     <= cmd_buffer_alfull;
			alfull_d2     <= alfull_d1;
		end
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("error: run stopped after %0d cycles, a job did not finish", cycle_count);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	////////////////////
	// assertions
	////////////////////

	a_quiet: assert property (@(posedge clock) disable iff (!rstn)
		quiet |-> !cmd_valid && !wr_data_0_valid && !wr_data_1_valid && !job_done &&
			!data_buffer_full && !data_buffer_alfull && job_counter_done == 0)
		else report_problem("outputs not idle after reset");

	a_data_valid: assert property (@(posedge clock) disable iff (!rstn)
		wr_data_0_valid == cmd_valid && wr_data_1_valid == cmd_valid)
		else report_problem("data valids do not match cmd_valid");

	a_known_entry: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid |-> issued < pushed_count)
		else report_problem("command issued with no pushed entry left");

	a_address: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid |-> cmd_address == exp_address)
		else report_value("cmd_address", $sampled(cmd_address), $sampled(exp_address));

	a_size_code: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid |-> cmd_size_code == exp_size_code)
		else report_value("cmd_size_code", $sampled(cmd_size_code), $sampled(exp_size_code));

	a_real_size: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid |-> cmd_real_size == pushed_size[issued])
		else report_value("cmd_real_size", $sampled(cmd_real_size),
			$sampled(pushed_size[issued]));

	a_half_0: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid |-> wr_data_0 == pushed_half_0[issued])
		else report_value("wr_data_0", $sampled(wr_data_0), $sampled(pushed_half_0[issued]));

	a_half_1: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid |-> wr_data_1 == pushed_half_1[issued])
		else report_value("wr_data_1", $sampled(wr_data_1), $sampled(pushed_half_1[issued]));

	a_opcode: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid |-> cmd_opcode == exp_opcode)
		else report_value("cmd_opcode", $sampled(cmd_opcode), $sampled(exp_opcode));

	a_window: assert property (@(posedge clock) disable iff (!rstn)
		issued - answered <= write_engine_pkg::WINDOW_REQS)
		else report_problem("more commands outstanding than one window allows");

	a_total: assert property (@(posedge clock) disable iff (!rstn)
		job_counter_done == resp_total_d2)
		else report_value("job_counter_done", $sampled(job_counter_done),
			$sampled(resp_total_d2));

	a_done: assert property (@(posedge clock) disable iff (!rstn)
		job_done |-> consumed >= job_size && issued == answered)
		else report_problem("job_done high before the job was sent and answered");

	a_backpressure: assert property (@(posedge clock) disable iff (!rstn)
		alfull_d2 |-> !cmd_valid)
		else report_problem("command issued while cmd_buffer_alfull was high");

	////////////////////
	// stimulus tasks
	////////////////////

	task automatic reset_dut();
		@(posedge clock);
		rstn       <= 1'b0;
		enable     <= 1'b0;
		job_valid  <= 1'b0;
		respond_on <= 1'b0;
		pushed_count = 0;
		job_total    = '0;
		repeat (4) @(posedge clock);
		rstn   <= 1'b1;
		enable <= 1'b1;
	endtask

	task automatic begin_test(string name);
		test_name = name;
		test_mark = error_count;
	endtask

	task automatic end_test();
		tests_run++;
		if (error_count != test_mark)
			tests_failed++;
		$display("test %0d %s: %0d errors", tests_run, test_name, error_count - test_mark);
	endtask

	task automatic gen_entries(input int n);
		for (int i = 0; i < n; i++) begin
			pushed_offset[i] = $urandom() & 32'hffff_ff80;
			pushed_size[i]   = 1 + ($urandom() % 40);
			pushed_half_0[i] = random_half();
			pushed_half_1[i] = random_half();
			job_total        = job_total + pushed_size[i];
		end
	endtask

	// stops pushing while the buffer reports almost full
	task automatic push_entries(input int first, input int last);
		int  i;
		bit  room;
		i = first;
		while (i < last) begin
			@(negedge clock);
			room = !data_buffer_alfull;
			@(posedge clock);
			if (room) begin
				data_0_valid  <= 1'b1;
				data_0_offset <= pushed_offset[i];
				data_0_size   <= pushed_size[i];
				data_0_half   <= pushed_half_0[i];
				data_1_valid  <= 1'b1;
				data_1_offset <= pushed_offset[i];
				data_1_size   <= pushed_size[i];
				data_1_half   <= pushed_half_1[i];
				i++;
				pushed_count = i;
			end else begin
				data_0_valid <= 1'b0;
				data_1_valid <= 1'b0;
			end
		end
		@(posedge clock);
		data_0_valid <= 1'b0;
		data_1_valid <= 1'b0;
	endtask

	task automatic start_job(input bit ms);
		@(posedge clock);
		ms_mode       <= ms;
		job_base_addr <= {$urandom(), $urandom()};
		job_size      <= job_total;
		job_valid     <= 1'b1;
	endtask

	task automatic wait_done(input int n);
		while (!job_done)
			@(negedge clock);
		@(posedge clock);
		job_valid <= 1'b0;
		repeat (4) @(posedge clock);
		@(negedge clock);
		assert (issued == n)
			else report_problem("not every entry of the job was issued");
	endtask

	task automatic run_job(input int n, input bit ms, input string name);
		reset_dut();
		begin_test(name);
		gen_entries(n);
		start_job(ms);
		respond_on <= 1'b1;
		fork
			push_entries(0, n);
			wait_done(n);
		join
		end_test();
	endtask

	////////////////////
	// test sequence
	////////////////////

	initial begin
		void'($urandom(SEED));
		rstn              = 1'b0;
		enable            = 1'b0;
		job_valid         = 1'b0;
		job_base_addr     = '0;
		job_size          = '0;
		ms_mode           = 1'b0;
		cmd_buffer_alfull = 1'b0;
		data_0_valid      = 1'b0;
		data_0_offset     = '0;
		data_0_size       = '0;
		data_0_half       = '0;
		data_1_valid      = 1'b0;
		data_1_offset     = '0;
		data_1_size       = '0;
		data_1_half       = '0;
		resp_valid        = 1'b0;
		resp_size         = '0;
		respond_on        = 1'b0;
		quiet             = 1'b0;
		error_count       = 0;
		tests_run         = 0;
		tests_failed      = 0;
		cycle_count       = 0;

		reset_dut();
		begin_test("idle after reset");
		quiet <= 1'b1;
		repeat (12) @(posedge clock);
		quiet <= 1'b0;
		end_test();

		run_job(10, 1'b0, "command fields");

		// first window goes out, then waits for its responses
		reset_dut();
		begin_test("window limit");
		gen_entries(20);
		start_job(1'b0);
		fork
			push_entries(0, 20);
			begin
				while (issued < write_engine_pkg::WINDOW_REQS)
					@(negedge clock);
				repeat (30) @(negedge clock);
				assert (issued == write_engine_pkg::WINDOW_REQS)
					else report_problem("window did not stop at its command limit");
				@(posedge clock);
				respond_on <= 1'b1;
				wait_done(20);
			end
		join
		end_test();

		run_job(12, 1'b1, "ms opcode");
		run_job(30, 1'b0, "job totals");

		reset_dut();
		begin_test("back-pressure");
		gen_entries(12);
		push_entries(0, 11);
		@(negedge clock);
		assert (!data_buffer_alfull)
			else report_problem("data_buffer_alfull high below the threshold");
		push_entries(11, 12);
		@(negedge clock);
		assert (data_buffer_alfull)
			else report_problem("data_buffer_alfull low at the threshold");
		@(posedge clock);
		cmd_buffer_alfull <= 1'b1;
		start_job(1'b0);
		respond_on <= 1'b1;
		repeat (30) @(negedge clock);
		assert (issued == 0)
			else report_problem("commands formed while cmd_buffer_alfull was high");
		@(posedge clock);
		cmd_buffer_alfull <= 1'b0;
		wait_done(12);
		end_test();

		$display("tests run %0d, failing %0d, errors %0d", tests_run, tests_failed, error_count);
		if (error_count == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// File: src/line_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module line_fifo #(
	parameter int WIDTH = 8
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             full,
	output logic             alfull,
	output logic             empty
);

	logic [WIDTH-1:0] mem [write_engine_pkg::BUFFER_DEPTH];

	logic [write_engine_pkg::BUFFER_PTR_W-1:0] wr_ptr;
	logic [write_engine_pkg::BUFFER_PTR_W-1:0] rd_ptr;
	logic [write_engine_pkg::BUFFER_CNT_W-1:0] count;
	logic                                      do_push;
	logic                                      do_pop;

	// pushes into a full FIFO and pops from an empty one are dropped
	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;

	// head is visible without a read cycle
	assign data_out = mem[rd_ptr];

	assign empty  = (count == 0);
	assign full   = (count == write_engine_pkg::BUFFER_DEPTH);
	assign alfull = (count >= (write_engine_pkg::BUFFER_DEPTH - write_engine_pkg::BUFFER_HEADROOM));

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
	end

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/response_tracker.sv
`timescale 1ns/100ps
`default_nettype none

module response_tracker (
	input  logic                                 clock,
	input  logic                                 rstn,
	input  logic                                 capture,
	input  logic                                 window_clear,
	input  logic                                 resp_valid,
	input  logic [write_engine_pkg::SIZE_W-1:0]  resp_size,
	output logic [write_engine_pkg::COUNT_W-1:0] resp_count,
	output logic [write_engine_pkg::SIZE_W-1:0]  job_counter_done
);

	logic                                resp_valid_q;
	logic [write_engine_pkg::SIZE_W-1:0] resp_size_q;

	// response latch
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			resp_valid_q <= 1'b0;
		else if (capture)
			resp_valid_q <= resp_valid;
	end

	always_ff @(posedge clock) begin
		if (capture && resp_valid)
			resp_size_q <= resp_size;
	end

	// window count and job element total
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			resp_count       <= '0;
			job_counter_done <= '0;
		end else begin
			if (window_clear)
				resp_count <= '0;
			else if (capture && resp_valid_q)
				resp_count <= resp_count + 1'b1;
			if (capture && resp_valid_q)
				job_counter_done <= job_counter_done + resp_size_q;
		end
	end

endmodule

`default_nettype wire

// File: src/write_cmd_builder.sv
`timescale 1ns/100ps
`default_nettype none

module write_cmd_builder (
	input  logic                                    clock,
	input  logic                                    rstn,
	input  logic                                    active,
	input  logic [write_engine_pkg::ADDR_W-1:0]     job_base_addr,
	input  logic [write_engine_pkg::SIZE_W-1:0]     job_size,
	input  logic                                    ms_mode,
	input  logic                                    cmd_buffer_alfull,
	input  logic                                    send_enable,
	input  logic                                    job_load,
	input  logic                                    window_clear,
	write_data_if.builder_side                      entry,
	output logic [1:0]                              send_stopped,
	output logic [write_engine_pkg::COUNT_W-1:0]    sent_count,
	output logic                                    cmd_valid,
	output logic [write_engine_pkg::ADDR_W-1:0]     cmd_address,
	output logic [write_engine_pkg::CMD_SIZE_W-1:0] cmd_size_code,
	output write_engine_pkg::write_opcode_e         cmd_opcode,
	output logic [write_engine_pkg::SIZE_W-1:0]     cmd_real_size,
	output logic                                    wr_data_0_valid,
	output logic [write_engine_pkg::HALF_W-1:0]     wr_data_0,
	output logic                                    wr_data_1_valid,
	output logic [write_engine_pkg::HALF_W-1:0]     wr_data_1
);

	logic [write_engine_pkg::ADDR_W-1:0]     base_addr;
	logic [write_engine_pkg::SIZE_W-1:0]     remaining;
	logic [write_engine_pkg::ADDR_W-1:0]     offset_ext;
	logic [write_engine_pkg::CMD_SIZE_W-1:0] size_code;
	logic                                    window_open;
	logic                                    pop;

	// first stage, loaded the cycle after a pop
	logic                                    s1_valid;
	logic [write_engine_pkg::ADDR_W-1:0]     s1_address;
	logic [write_engine_pkg::CMD_SIZE_W-1:0] s1_size_code;
	write_engine_pkg::write_opcode_e         s1_opcode;
	logic [write_engine_pkg::SIZE_W-1:0]     s1_real_size;
	logic [write_engine_pkg::HALF_W-1:0]     s1_half_0;
	logic [write_engine_pkg::HALF_W-1:0]     s1_half_1;

	////////////////////
	// issue decision
	////////////////////

	assign window_open = (sent_count < write_engine_pkg::WINDOW_REQS);

	// bit 1 job finished, bit 0 window full
	assign send_stopped = {~(|remaining), ~window_open};

	assign pop = active & send_enable & ~cmd_buffer_alfull & entry.entry_valid &
		window_open & (|remaining);
	assign entry.pop = pop;

	assign offset_ext = {{(write_engine_pkg::ADDR_W - write_engine_pkg::OFFSET_W){1'b0}},
		entry.entry_offset};

	// bytes on the bus, never more than one line
	always_comb begin
		if (entry.entry_size >= (write_engine_pkg::LINE_BYTES / write_engine_pkg::ELEMENT_BYTES))
			size_code = write_engine_pkg::CMD_SIZE_W'(write_engine_pkg::LINE_BYTES);
		else
			size_code = write_engine_pkg::CMD_SIZE_W'(entry.entry_size *
				write_engine_pkg::ELEMENT_BYTES);
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			remaining  <= '0;
			sent_count <= '0;
			s1_valid   <= 1'b0;
		end else if (active) begin
			s1_valid <= pop;
			if (job_load)
				remaining <= job_size;
			else if (pop)
				remaining <= (entry.entry_size >= remaining) ? '0 : remaining - entry.entry_size;
			if (window_clear)
				sent_count <= '0;
			else if (pop)
				sent_count <= sent_count + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (active && job_load)
			base_addr <= job_base_addr;
		if (pop) begin
			s1_address   <= base_addr + offset_ext;
			s1_size_code <= size_code;
			s1_opcode    <= ms_mode ? write_engine_pkg::WRITE_MS : write_engine_pkg::WRITE_NA;
			s1_real_size <= entry.entry_size;
			s1_half_0    <= entry.entry_half_0;
			s1_half_1    <= entry.entry_half_1;
		end
	end

	////////////////////
	// output stage
	////////////////////

	// frozen while disabled
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cmd_valid       <= 1'b0;
			wr_data_0_valid <= 1'b0;
			wr_data_1_valid <= 1'b0;
		end else if (active) begin
			cmd_valid       <= s1_valid;
			wr_data_0_valid <= s1_valid;
			wr_data_1_valid <= s1_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (active) begin
			cmd_address   <= s1_address;
			cmd_size_code <= s1_size_code;
			cmd_opcode    <= s1_opcode;
			cmd_real_size <= s1_real_size;
			wr_data_0     <= s1_half_0;
			wr_data_1     <= s1_half_1;
		end
	end

endmodule

`default_nettype wire

// File: src/write_data_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module write_data_buffer (
	input  logic                                  clock,
	input  logic                                  rstn,
	input  logic                                  data_0_valid,
	input  logic [write_engine_pkg::OFFSET_W-1:0] data_0_offset,
	input  logic [write_engine_pkg::SIZE_W-1:0]   data_0_size,
	input  logic [write_engine_pkg::HALF_W-1:0]   data_0_half,
	input  logic                                  data_1_valid,
	input  logic [write_engine_pkg::OFFSET_W-1:0] data_1_offset,
	input  logic [write_engine_pkg::SIZE_W-1:0]   data_1_size,
	input  logic [write_engine_pkg::HALF_W-1:0]   data_1_half,
	write_data_if.buffer_side                     entry,
	output logic                                  full,
	output logic                                  alfull
);

	logic [write_engine_pkg::ENTRY_W-1:0] record_0_in;
	logic [write_engine_pkg::ENTRY_W-1:0] record_1_in;
	logic [write_engine_pkg::ENTRY_W-1:0] record_0_out;
	logic [write_engine_pkg::ENTRY_W-1:0] record_1_out;
	logic                                 empty_0;
	logic                                 empty_1;

	// record layout is offset, size, half from msb down
	assign record_0_in = {data_0_offset, data_0_size, data_0_half};
	assign record_1_in = {data_1_offset, data_1_size, data_1_half};

	// status toward the source comes from FIFO 0
	line_fifo #(.WIDTH(write_engine_pkg::ENTRY_W)) fifo_0_i (
		.clock    (clock),
		.rstn     (rstn),
		.push     (data_0_valid),
		.data_in  (record_0_in),
		.pop      (entry.pop),
		.data_out (record_0_out),
		.full     (full),
		.alfull   (alfull),
		.empty    (empty_0)
	);

	line_fifo #(.WIDTH(write_engine_pkg::ENTRY_W)) fifo_1_i (
		.clock    (clock),
		.rstn     (rstn),
		.push     (data_1_valid),
		.data_in  (record_1_in),
		.pop      (entry.pop),
		.data_out (record_1_out),
		.full     (),
		.alfull   (),
		.empty    (empty_1)
	);

	// an entry needs both halves present
	assign entry.entry_valid  = ~empty_0 & ~empty_1;
	assign entry.entry_offset = record_0_out[write_engine_pkg::ENTRY_W-1 -: write_engine_pkg::OFFSET_W];
	assign entry.entry_size   = record_0_out[write_engine_pkg::HALF_W +: write_engine_pkg::SIZE_W];
	assign entry.entry_half_0 = record_0_out[write_engine_pkg::HALF_W-1:0];
	assign entry.entry_half_1 = record_1_out[write_engine_pkg::HALF_W-1:0];

endmodule

`default_nettype wire

// File: src/write_data_if.sv
`timescale 1ns/100ps
`default_nettype none

interface write_data_if;

	// paired head entry of the two data FIFOs
	logic                                  entry_valid;
	logic [write_engine_pkg::OFFSET_W-1:0] entry_offset;
	logic [write_engine_pkg::SIZE_W-1:0]   entry_size;
	logic [write_engine_pkg::HALF_W-1:0]   entry_half_0;
	logic [write_engine_pkg::HALF_W-1:0]   entry_half_1;

	// removes the head of both FIFOs at once
	logic                                  pop;

	modport buffer_side (
		output entry_valid,
		output entry_offset,
		output entry_size,
		output entry_half_0,
		output entry_half_1,
		input  pop
	);

	modport builder_side (
		input  entry_valid,
		input  entry_offset,
		input  entry_size,
		input  entry_half_0,
		input  entry_half_1,
		output pop
	);

endinterface

`default_nettype wire

// File: src/write_engine_pkg.sv
`default_nettype none

package write_engine_pkg;

	////////////////////
	// widths
	////////////////////

	localparam int ADDR_W     = 64;
	localparam int HALF_W     = 512;
	localparam int OFFSET_W   = 32;
	localparam int SIZE_W     = 32;
	localparam int CMD_SIZE_W = 12;
	localparam int OPCODE_W   = 13;

	// one buffered record is offset, size and half
	localparam int ENTRY_W = OFFSET_W + SIZE_W + HALF_W;

	////////////////////
	// sizes and limits
	////////////////////

	localparam int ELEMENT_BYTES = 4;
	localparam int LINE_BYTES    = 128;

	localparam int BUFFER_DEPTH    = 16;
	localparam int BUFFER_HEADROOM = 4;
	localparam int BUFFER_PTR_W    = 4;
	localparam int BUFFER_CNT_W    = 5;

	// commands per window before waiting on responses
	localparam int WINDOW_REQS = 8;
	localparam int COUNT_W     = 4;

	////////////////////
	// encodings
	////////////////////

	typedef enum logic [OPCODE_W-1:0] {
		WRITE_NA = 13'h0D00,
		WRITE_MS = 13'h0D60
	} write_opcode_e;

	typedef enum logic [2:0] {
		RESET,
		IDLE,
		SET,
		START,
		REQ,
		PENDING,
		DONE,
		FINAL
	} stream_state_e;

endpackage

`default_nettype wire

// File: src/write_engine_top.sv
`timescale 1ns/100ps
`default_nettype none

module write_engine_top (
	input  logic                                    clock,
	input  logic                                    rstn,
	input  logic                                    enable,
	input  logic                                    job_valid,
	input  logic [write_engine_pkg::ADDR_W-1:0]     job_base_addr,
	input  logic [write_engine_pkg::SIZE_W-1:0]     job_size,
	input  logic                                    ms_mode,
	input  logic                                    cmd_buffer_alfull,
	input  logic                                    data_0_valid,
	input  logic [write_engine_pkg::OFFSET_W-1:0]   data_0_offset,
	input  logic [write_engine_pkg::SIZE_W-1:0]     data_0_size,
	input  logic [write_engine_pkg::HALF_W-1:0]     data_0_half,
	input  logic                                    data_1_valid,
	input  logic [write_engine_pkg::OFFSET_W-1:0]   data_1_offset,
	input  logic [write_engine_pkg::SIZE_W-1:0]     data_1_size,
	input  logic [write_engine_pkg::HALF_W-1:0]     data_1_half,
	input  logic                                    resp_valid,
	input  logic [write_engine_pkg::SIZE_W-1:0]     resp_size,
	output logic                                    cmd_valid,
	output logic [write_engine_pkg::ADDR_W-1:0]     cmd_address,
	output logic [write_engine_pkg::CMD_SIZE_W-1:0] cmd_size_code,
	output logic [write_engine_pkg::OPCODE_W-1:0]   cmd_opcode,
	output logic [write_engine_pkg::SIZE_W-1:0]     cmd_real_size,
	output logic                                    wr_data_0_valid,
	output logic [write_engine_pkg::HALF_W-1:0]     wr_data_0,
	output logic                                    wr_data_1_valid,
	output logic [write_engine_pkg::HALF_W-1:0]     wr_data_1,
	output logic                                    data_buffer_full,
	output logic                                    data_buffer_alfull,
	output logic [write_engine_pkg::SIZE_W-1:0]     job_counter_done,
	output logic                                    job_done
);

	logic                                 enabled;
	logic                                 enabled_cmd;
	logic                                 send_enable;
	logic                                 job_load;
	logic                                 window_clear;
	logic [1:0]                           send_stopped;
	logic [write_engine_pkg::COUNT_W-1:0] sent_count;
	logic [write_engine_pkg::COUNT_W-1:0] resp_count;

	write_data_if entry_bus ();

	////////////////////
	// enable stages
	////////////////////

	// second stage gates the response latch and job acceptance
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled     <= 1'b0;
			enabled_cmd <= 1'b0;
		end else begin
			enabled     <= enable;
			enabled_cmd <= enabled;
		end
	end

	write_data_buffer buffer_i (
		.clock         (clock),
		.rstn          (rstn),
		.data_0_valid  (data_0_valid),
		.data_0_offset (data_0_offset),
		.data_0_size   (data_0_size),
		.data_0_half   (data_0_half),
		.data_1_valid  (data_1_valid),
		.data_1_offset (data_1_offset),
		.data_1_size   (data_1_size),
		.data_1_half   (data_1_half),
		.entry         (entry_bus.buffer_side),
		.full          (data_buffer_full),
		.alfull        (data_buffer_alfull)
	);

	write_cmd_builder builder_i (
		.clock             (clock),
		.rstn              (rstn),
		.active            (enabled),
		.job_base_addr     (job_base_addr),
		.job_size          (job_size),
		.ms_mode           (ms_mode),
		.cmd_buffer_alfull (cmd_buffer_alfull),
		.send_enable       (send_enable),
		.job_load          (job_load),
		.window_clear      (window_clear),
		.entry             (entry_bus.builder_side),
		.send_stopped      (send_stopped),
		.sent_count        (sent_count),
		.cmd_valid         (cmd_valid),
		.cmd_address       (cmd_address),
		.cmd_size_code     (cmd_size_code),
		.cmd_opcode        (cmd_opcode),
		.cmd_real_size     (cmd_real_size),
		.wr_data_0_valid   (wr_data_0_valid),
		.wr_data_0         (wr_data_0),
		.wr_data_1_valid   (wr_data_1_valid),
		.wr_data_1         (wr_data_1)
	);

	response_tracker tracker_i (
		.clock            (clock),
		.rstn             (rstn),
		.capture          (enabled_cmd),
		.window_clear     (window_clear),
		.resp_valid       (resp_valid),
		.resp_size        (resp_size),
		.resp_count       (resp_count),
		.job_counter_done (job_counter_done)
	);

	write_stream_ctrl ctrl_i (
		.clock        (clock),
		.rstn         (rstn),
		.active       (enabled),
		.armed        (enabled_cmd),
		.job_valid    (job_valid),
		.send_stopped (send_stopped),
		.sent_count   (sent_count),
		.resp_count   (resp_count),
		.send_enable  (send_enable),
		.job_load     (job_load),
		.window_clear (window_clear),
		.job_done     (job_done)
	);

endmodule

`default_nettype wire

// File: src/write_stream_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module write_stream_ctrl (
	input  logic                                 clock,
	input  logic                                 rstn,
	input  logic                                 active,
	input  logic                                 armed,
	input  logic                                 job_valid,
	input  logic [1:0]                           send_stopped,
	input  logic [write_engine_pkg::COUNT_W-1:0] sent_count,
	input  logic [write_engine_pkg::COUNT_W-1:0] resp_count,
	output logic                                 send_enable,
	output logic                                 job_load,
	output logic                                 window_clear,
	output logic                                 job_done
);

	write_engine_pkg::stream_state_e state;
	write_engine_pkg::stream_state_e next_state;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			state <= write_engine_pkg::RESET;
		else if (active)
			state <= next_state;
	end

	////////////////////
	// next state
	////////////////////

	always_comb begin
		next_state = state;
		case (state)
			write_engine_pkg::RESET: begin
				next_state = write_engine_pkg::IDLE;
			end
			write_engine_pkg::IDLE: begin
				if (job_valid && armed)
					next_state = write_engine_pkg::SET;
			end
			write_engine_pkg::SET: begin
				next_state = write_engine_pkg::START;
			end
			write_engine_pkg::START: begin
				next_state = write_engine_pkg::REQ;
			end
			write_engine_pkg::REQ: begin
				// window full or nothing left to send
				if (|send_stopped)
					next_state = write_engine_pkg::PENDING;
			end
			write_engine_pkg::PENDING: begin
				// every command of this window answered
				if (resp_count == sent_count)
					next_state = write_engine_pkg::DONE;
			end
			write_engine_pkg::DONE: begin
				if (send_stopped[1])
					next_state = write_engine_pkg::FINAL;
				else
					next_state = write_engine_pkg::START;
			end
			write_engine_pkg::FINAL: begin
				next_state = write_engine_pkg::FINAL;
			end
			default: begin
				next_state = write_engine_pkg::RESET;
			end
		endcase
	end

	////////////////////
	// state decode
	////////////////////

	assign job_load     = (state == write_engine_pkg::SET);
	assign window_clear = (state == write_engine_pkg::START);
	// high for the whole request phase that follows START
	assign send_enable  = (state == write_engine_pkg::REQ);
	assign job_done     = (state == write_engine_pkg::FINAL);

endmodule

`default_nettype wire

// File: write_engine.f
src/write_engine_pkg.sv
src/write_data_if.sv
src/line_fifo.sv
src/write_data_buffer.sv
src/write_cmd_builder.sv
src/response_tracker.sv
src/write_stream_ctrl.sv
src/write_engine_top.sv
sim/write_engine_tb.sv
